// File: hdl/img_pkg.sv
`default_nettype none

package img_pkg;

    // ================================================
    // Widths
    // ================================================
    localparam int WORD_W  = 16;
    localparam int PIX_W   = 12;
    localparam int COUNT_W = 16;

    // ================================================
    // Enums
    // ================================================
    typedef enum logic {
        CMD_CAPTURE,
        CMD_READOUT
    } cmd_op_e;

    typedef enum logic [2:0] {
        CAP_IDLE,
        CAP_HEADER,
        CAP_WAIT_INVALID,
        CAP_WAIT_VALID,
        CAP_FRAME,
        CAP_CSUM_A,
        CAP_CSUM_B,
        CAP_DONE
    } cap_state_e;

    typedef enum logic [2:0] {
        CTRL_IDLE,
        CTRL_CAPTURE,
        CTRL_CAP_FINISH,
        CTRL_READOUT,
        CTRL_ACK
    } ctrl_state_e;

    // ================================================
    // Structs
    // ================================================
    // Sensor pixel bus, already in the clk domain
    typedef struct packed {
        logic             fv;
        logic             lv;
        logic [PIX_W-1:0] d;
    } pixel_bus_t;

    // One word written into the frame store
    typedef struct packed {
        logic               en;
        logic               block;
        logic [COUNT_W-1:0] addr;
        logic [WORD_W-1:0]  data;
    } store_wr_t;

    typedef struct packed {
        logic [COUNT_W-1:0] word_count;
        logic [COUNT_W-1:0] highlight_count;
        logic [COUNT_W-1:0] shadow_count;
    } capture_status_t;

endpackage

`default_nettype wire

// File: hdl/fletcher_checksum.sv
`timescale 1ns/1ps
`default_nettype none

module fletcher_checksum (
    input  logic        clk,
    input  logic        readout_rst,
    input  logic        clear,
    input  logic        en,
    input  logic [15:0] word,
    output logic [15:0] sum_a,
    output logic [15:0] sum_b
);

    logic [15:0] next_a;

    // Add modulo 65535, carry folded back into bit 0
    function automatic logic [15:0] add_mod(input logic [15:0] x, input logic [15:0] y);
        logic [16:0] s;
        logic [15:0] f;
        s = {1'b0, x} + {1'b0, y};
        f = s[15:0] + {15'd0, s[16]};
        // All ones is the second encoding of zero
        return (f == 16'hffff) ? 16'h0000 : f;
    endfunction

    assign next_a = add_mod(sum_a, word);

    always_ff @(posedge clk) begin
        if (!readout_rst || clear) begin
            sum_a <= '0;
            sum_b <= '0;
        end else if (en) begin
            sum_a <= next_a;
            // b accumulates the updated a
            sum_b <= add_mod(sum_b, next_a);
        end
    end

endmodule

`default_nettype wire

// File: hdl/pixel_stats.sv
`timescale 1ns/1ps
`default_nettype none

module pixel_stats (
    input  logic                        clk,
    input  logic                        readout_rst,
    input  logic                        start,
    input  logic                        frame_window,
    input  img_pkg::pixel_bus_t         pix,
    output logic [img_pkg::COUNT_W-1:0] highlight_count,
    output logic [img_pkg::COUNT_W-1:0] shadow_count
);
    import img_pkg::*;

    logic             lv_q;
    logic [1:0]       col;
    logic [1:0]       row;
    logic             samp_en;
    logic [PIX_W-1:0] samp_d;
    logic [6:0]       samp_top;

    assign samp_top = samp_d[PIX_W-1 -: 7];

    // Sampled pixel value, qualified by samp_en
    always_ff @(posedge clk) begin
        samp_d <= pix.d;
    end

    always_ff @(posedge clk) begin
        if (!readout_rst) begin
            lv_q            <= 1'b0;
            col             <= '0;
            row             <= '0;
            samp_en         <= 1'b0;
            highlight_count <= '0;
            shadow_count    <= '0;
        end else begin
            lv_q <= pix.lv;

            // Only the position modulo 4 matters
            col <= pix.lv ? col + 2'd1 : 2'd0;
            if (!pix.fv) begin
                row <= '0;
            end else if (lv_q && !pix.lv) begin
                row <= row + 2'd1;
            end

            samp_en <= frame_window && pix.lv && (col == 2'd0) && (row == 2'd0);

            if (start) begin
                highlight_count <= '0;
                shadow_count    <= '0;
            end else if (samp_en) begin
                // Saturating counts
                if (&samp_top && (highlight_count != '1)) begin
                    highlight_count <= highlight_count + 1'b1;
                end
                if (!(|samp_top) && (shadow_count != '1)) begin
                    shadow_count <= shadow_count + 1'b1;
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: hdl/capture_writer.sv
`timescale 1ns/1ps
`default_nettype none

module capture_writer #(
    parameter int HEADER_WORDS  = 4,
    parameter int MAX_IMG_WORDS = 512
) (
    input  logic                        clk,
    input  logic                        readout_rst,
    input  logic                        start,
    input  logic                        block,
    input  logic [HEADER_WORDS*16-1:0]  header,
    input  img_pkg::pixel_bus_t         pix,
    output img_pkg::store_wr_t          store_wr,
    output logic                        frame_window,
    output logic [img_pkg::COUNT_W-1:0] word_count,
    output logic                        done
);
    import img_pkg::*;

    localparam int HDR_W = HEADER_WORDS * 16;
    localparam int HL_W  = $clog2(HEADER_WORDS + 1);

    cap_state_e         state;
    logic [HDR_W-1:0]   hdr_sr;
    logic [HL_W-1:0]    hdr_left;
    logic               blk;
    logic [COUNT_W-1:0] addr_cnt;

    logic               wr_block;
    logic [COUNT_W-1:0] wr_addr;
    logic               room;
    logic               data_req;
    logic               data_en;
    logic               csum_req;
    logic               nxt_en;
    logic [WORD_W-1:0]  data_word;
    logic [WORD_W-1:0]  nxt_data;
    logic [15:0]        sum_a;
    logic [15:0]        sum_b;

    // ================================================
    // Next write
    // ================================================
    // The start cycle already writes header word 0 at address 0
    assign wr_block = (state == CAP_IDLE) ? block : blk;
    assign wr_addr  = (state == CAP_IDLE) ? '0 : addr_cnt;

    // Two words are kept free for the checksum
    assign room = wr_addr < COUNT_W'(MAX_IMG_WORDS - 2);

    assign frame_window = pix.fv && ((state == CAP_WAIT_VALID) || (state == CAP_FRAME));

    always_comb begin
        data_req  = 1'b0;
        data_word = WORD_W'(pix.d);
        case (state)
            CAP_IDLE: begin
                data_req  = start;
                data_word = header[HDR_W-1 -: WORD_W];
            end
            CAP_HEADER: begin
                data_req  = 1'b1;
                data_word = hdr_sr[HDR_W-1 -: WORD_W];
            end
            CAP_WAIT_VALID, CAP_FRAME: begin
                data_req = frame_window && pix.lv;
            end
            default: begin
                data_req = 1'b0;
            end
        endcase
    end

    assign data_en  = data_req && room;
    assign csum_req = ((state == CAP_FRAME) && !pix.fv) || (state == CAP_CSUM_A);
    assign nxt_en   = data_en || csum_req;

    always_comb begin
        if (state == CAP_CSUM_A) begin
            nxt_data = sum_b;
        end else if (csum_req) begin
            nxt_data = sum_a;
        end else begin
            nxt_data = data_word;
        end
    end

    // Sums already include the word being registered this cycle
    fletcher_checksum u_checksum (
        .clk         (clk),
        .readout_rst (readout_rst),
        .clear       (state == CAP_DONE),
        .en          (data_en),
        .word        (data_word),
        .sum_a       (sum_a),
        .sum_b       (sum_b)
    );

    // ================================================
    // Sequencer
    // ================================================
    always_ff @(posedge clk) begin
        if (!readout_rst) begin
            state    <= CAP_IDLE;
            store_wr <= '0;
            hdr_left <= '0;
            blk      <= 1'b0;
            addr_cnt <= '0;
        end else begin
            store_wr <= '{en: nxt_en, block: wr_block, addr: wr_addr, data: nxt_data};
            if (nxt_en) begin
                addr_cnt <= wr_addr + 1'b1;
            end

            case (state)
                CAP_IDLE: begin
                    if (start) begin
                        blk      <= block;
                        hdr_left <= HL_W'(HEADER_WORDS - 1);
                        state    <= (HEADER_WORDS > 1) ? CAP_HEADER : CAP_WAIT_INVALID;
                    end
                end
                CAP_HEADER: begin
                    hdr_left <= hdr_left - 1'b1;
                    if (hdr_left == HL_W'(1)) begin
                        state <= CAP_WAIT_INVALID;
                    end
                end
                // Skip any frame already in progress
                CAP_WAIT_INVALID: if (!pix.fv) state <= CAP_WAIT_VALID;
                CAP_WAIT_VALID:   if (pix.fv) state <= CAP_FRAME;
                CAP_FRAME:        if (!pix.fv) state <= CAP_CSUM_A;
                CAP_CSUM_A:       state <= CAP_CSUM_B;
                CAP_CSUM_B:       state <= CAP_DONE;
                default:          state <= CAP_IDLE;
            endcase
        end
    end

    // Header shifts out most significant word first
    always_ff @(posedge clk) begin
        if (state == CAP_IDLE) begin
            hdr_sr <= header << WORD_W;
        end else if (state == CAP_HEADER) begin
            hdr_sr <= hdr_sr << WORD_W;
        end
    end

    assign word_count = addr_cnt;
    assign done       = (state == CAP_DONE);

endmodule

`default_nettype wire

// File: hdl/frame_store.sv
`timescale 1ns/1ps
`default_nettype none

module frame_store #(
    parameter int MAX_IMG_WORDS = 512
) (
    input  logic                        clk,
    input  img_pkg::store_wr_t          wr,
    input  logic                        rd_block,
    input  logic [img_pkg::COUNT_W-1:0] rd_addr,
    output logic [15:0]                 rd_data
);
    import img_pkg::*;

    logic [WORD_W-1:0] mem [2*MAX_IMG_WORDS];

    // Block 1 occupies the upper half
    function automatic int word_index(input logic blk, input logic [COUNT_W-1:0] addr);
        return (blk ? MAX_IMG_WORDS : 0) + int'(addr);
    endfunction

    always_ff @(posedge clk) begin
        if (wr.en) begin
            mem[word_index(wr.block, wr.addr)] <= wr.data;
        end
        rd_data <= mem[word_index(rd_block, rd_addr)];
    end

endmodule

`default_nettype wire

// File: hdl/img_controller.sv
`timescale 1ns/1ps
`default_nettype none

module img_controller #(
    parameter int HEADER_WORDS = 4
) (
    input  logic                        clk,
    input  logic                        readout_rst,
    input  logic                        cmd_req,
    output logic                        cmd_ack,
    input  img_pkg::cmd_op_e            cmd_op,
    input  logic                        cmd_block,
    input  logic [HEADER_WORDS*16-1:0]  cmd_header,
    output logic                        wr_start,
    output logic                        wr_block,
    output logic [HEADER_WORDS*16-1:0]  wr_header,
    input  logic                        wr_done,
    input  logic [img_pkg::COUNT_W-1:0] word_count,
    input  logic [img_pkg::COUNT_W-1:0] highlight_count,
    input  logic [img_pkg::COUNT_W-1:0] shadow_count,
    output logic                        rd_block,
    output logic [img_pkg::COUNT_W-1:0] rd_addr,
    input  logic [15:0]                 rd_data,
    output logic                        readout_ready,
    input  logic                        readout_trigger,
    output logic [15:0]                 readout_data,
    output img_pkg::capture_status_t    status
);
    import img_pkg::*;

    ctrl_state_e        state;
    logic [COUNT_W-1:0] blk_words [2];
    logic [COUNT_W-1:0] load_left;
    logic [COUNT_W-1:0] addr_q;
    logic               fire;
    logic               load;

    // ================================================
    // Readout datapath
    // ================================================
    assign fire = readout_ready && readout_trigger;

    // Refill the output register when it is empty or being drained
    assign load = (state == CTRL_READOUT) && (load_left != '0) && (!readout_ready || fire);

    // cmd_block is stable for the whole command
    assign rd_block = cmd_block;

    // rd_data always holds the word at addr_q, so it doubles as the skid entry
    always_comb begin
        if (state != CTRL_READOUT) begin
            rd_addr = '0;
        end else if (load) begin
            rd_addr = addr_q + 1'b1;
        end else begin
            rd_addr = addr_q;
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            readout_data <= rd_data;
        end
    end

    assign status = '{
        word_count:      word_count,
        highlight_count: highlight_count,
        shadow_count:    shadow_count
    };

    // ================================================
    // Command FSM
    // ================================================
    always_ff @(posedge clk) begin
        if (state == CTRL_IDLE && cmd_req) begin
            wr_block  <= cmd_block;
            wr_header <= cmd_header;
        end
    end

    always_ff @(posedge clk) begin
        if (!readout_rst) begin
            state         <= CTRL_IDLE;
            cmd_ack       <= 1'b0;
            wr_start      <= 1'b0;
            readout_ready <= 1'b0;
            blk_words[0]  <= '0;
            blk_words[1]  <= '0;
            load_left     <= '0;
            addr_q        <= '0;
        end else begin
            wr_start <= 1'b0;
            addr_q   <= rd_addr;

            case (state)
                CTRL_IDLE: begin
                    if (cmd_req) begin
                        if (cmd_op == CMD_CAPTURE) begin
                            wr_start <= 1'b1;
                            state    <= CTRL_CAPTURE;
                        end else begin
                            load_left <= blk_words[cmd_block];
                            state     <= CTRL_READOUT;
                        end
                    end
                end
                CTRL_CAPTURE: begin
                    if (wr_done) begin
                        blk_words[wr_block] <= word_count;
                        state               <= CTRL_CAP_FINISH;
                    end
                end
                CTRL_CAP_FINISH: begin
                    cmd_ack <= 1'b1;
                    state   <= CTRL_ACK;
                end
                CTRL_READOUT: begin
                    if (load) begin
                        readout_ready <= 1'b1;
                        load_left     <= load_left - 1'b1;
                    end else if (fire) begin
                        readout_ready <= 1'b0;
                    end
                    // Last word gone, or nothing to send at all
                    if ((load_left == '0) && (fire || !readout_ready)) begin
                        cmd_ack <= 1'b1;
                        state   <= CTRL_ACK;
                    end
                end
                CTRL_ACK: begin
                    if (!cmd_req) begin
                        cmd_ack <= 1'b0;
                        state   <= CTRL_IDLE;
                    end
                end
                default: state <= CTRL_IDLE;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: hdl/img_top.sv
`timescale 1ns/1ps
`default_nettype none

module img_top #(
    parameter int HEADER_WORDS  = 4,
    parameter int MAX_IMG_WORDS = 512
) (
    input  logic                        clk,
    input  logic                        readout_rst,
    input  logic                        cmd_req,
    output logic                        cmd_ack,
    input  img_pkg::cmd_op_e            cmd_op,
    input  logic                        cmd_block,
    input  logic [HEADER_WORDS*16-1:0]  cmd_header,
    input  img_pkg::pixel_bus_t         pix,
    output logic                        readout_ready,
    input  logic                        readout_trigger,
    output logic [15:0]                 readout_data,
    output img_pkg::capture_status_t    status
);
    import img_pkg::*;

    logic                      wr_start;
    logic                      wr_block;
    logic [HEADER_WORDS*16-1:0] wr_header;
    logic                      wr_done;
    logic [COUNT_W-1:0]        word_count;
    logic [COUNT_W-1:0]        highlight_count;
    logic [COUNT_W-1:0]        shadow_count;
    logic                      frame_window;
    store_wr_t                 store_wr;
    logic                      rd_block;
    logic [COUNT_W-1:0]        rd_addr;
    logic [15:0]               rd_data;

    img_controller #(
        .HEADER_WORDS (HEADER_WORDS)
    ) u_controller (
        .clk             (clk),
        .readout_rst     (readout_rst),
        .cmd_req         (cmd_req),
        .cmd_ack         (cmd_ack),
        .cmd_op          (cmd_op),
        .cmd_block       (cmd_block),
        .cmd_header      (cmd_header),
        .wr_start        (wr_start),
        .wr_block        (wr_block),
        .wr_header       (wr_header),
        .wr_done         (wr_done),
        .word_count      (word_count),
        .highlight_count (highlight_count),
        .shadow_count    (shadow_count),
        .rd_block        (rd_block),
        .rd_addr         (rd_addr),
        .rd_data         (rd_data),
        .readout_ready   (readout_ready),
        .readout_trigger (readout_trigger),
        .readout_data    (readout_data),
        .status          (status)
    );

    // Capture writer and statistics watch the pixel bus side by side
    capture_writer #(
        .HEADER_WORDS  (HEADER_WORDS),
        .MAX_IMG_WORDS (MAX_IMG_WORDS)
    ) u_writer (
        .clk          (clk),
        .readout_rst  (readout_rst),
        .start        (wr_start),
        .block        (wr_block),
        .header       (wr_header),
        .pix          (pix),
        .store_wr     (store_wr),
        .frame_window (frame_window),
        .word_count   (word_count),
        .done         (wr_done)
    );

    pixel_stats u_stats (
        .clk             (clk),
        .readout_rst     (readout_rst),
        .start           (wr_start),
        .frame_window    (frame_window),
        .pix             (pix),
        .highlight_count (highlight_count),
        .shadow_count    (shadow_count)
    );

    frame_store #(
        .MAX_IMG_WORDS (MAX_IMG_WORDS)
    ) u_store (
        .clk      (clk),
        .wr       (store_wr),
        .rd_block (rd_block),
        .rd_addr  (rd_addr),
        .rd_data  (rd_data)
    );

endmodule

`default_nettype wire

// File: test/img_tb_tasks.svh
`ifndef IMG_TB_TASKS_SVH
`define IMG_TB_TASKS_SVH

// ================================================
// Small helpers
// ================================================
task automatic idle_cycles(input int n);
    repeat (n) @(negedge clk);
endtask

task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
        $display("[ERROR] %s: got %h expected %h", name, got, exp);
        errors++;
    end
endtask

function automatic logic [HDR_W-1:0] random_header();
    logic [HDR_W-1:0] h;
    h = '0;
    for (int i = 0; i < HEADER_WORDS; i++) begin
        h[i*16 +: 16] = 16'($random(seed));
    end
    return h;
endfunction

// Highlight, shadow and mid-range values spread over the frame
function automatic logic [11:0] pattern_pixel(input int r, input int c);
    case ((r + c + r / 4 + 2 * (c / 4)) % 4)
        0:       return 12'hfff;
        1:       return 12'h01f;
        2:       return 12'h800;
        default: return 12'hfe0;
    endcase
endfunction

// Pixel word plus statistics by the sampling rule
task automatic model_pixel(input int r, input int c, input logic [11:0] d);
    pix_words.push_back({4'h0, d});
    if ((r % 4 == 0) && (c % 4 == 0)) begin
        if (d[11:5] == 7'h7f) begin
            exp_high++;
        end else if (d[11:5] == 7'h00) begin
            exp_shadow++;
        end
    end
endtask

// ================================================
// Pixel bus
// ================================================
task automatic drive_frame(input int rows, input int cols, input int mode, input bit record);
    logic [11:0] d;
    @(negedge clk);
    pix.fv = 1'b1;
    pix.lv = 1'b0;
    idle_cycles(2);
    for (int r = 0; r < rows; r++) begin
        for (int c = 0; c < cols; c++) begin
            d = (mode == 1) ? pattern_pixel(r, c) : 12'($random(seed));
            pix.lv = 1'b1;
            pix.d  = d;
            if (record) begin
                model_pixel(r, c, d);
            end
            @(negedge clk);
        end
        // Line blanking
        pix.lv = 1'b0;
        idle_cycles(3);
    end
    pix = '0;
endtask

// Header, stored pixels, then Fletcher-32 words a and b
task automatic build_expected(input logic [HDR_W-1:0] hdr);
    int a;
    int b;
    exp_words.delete();
    for (int i = HEADER_WORDS - 1; i >= 0; i--) begin
        exp_words.push_back(hdr[i*16 +: 16]);
    end
    // Two words of each block stay free for the checksum
    foreach (pix_words[i]) begin
        if (exp_words.size() < MAX_WORDS - 2) begin
            exp_words.push_back(pix_words[i]);
        end
    end
    a = 0;
    b = 0;
    foreach (exp_words[i]) begin
        a = (a + exp_words[i]) % 65535;
        b = (b + a) % 65535;
    end
    exp_words.push_back(a[15:0]);
    exp_words.push_back(b[15:0]);
endtask

// ================================================
// Command port
// ================================================
task automatic wait_ack(input logic level, input string what);
    int n;
    n = 0;
    while ((cmd_ack !== level) && (n < ACK_LIMIT)) begin
        @(negedge clk);
        n++;
    end
    if (cmd_ack !== level) begin
        $display("Timeout: cmd_ack never went to %0d during %s", level, what);
        timeouts++;
    end
endtask

task automatic release_command();
    cmd_req = 1'b0;
    wait_ack(1'b0, "command release");
endtask

task automatic capture_frame(input logic blk, input logic [HDR_W-1:0] hdr, input int rows,
                             input int cols, input int mode, input bit skip_running);
    pix_words.delete();
    exp_high   = 0;
    exp_shadow = 0;
    @(negedge clk);
    cmd_op     = CMD_CAPTURE;
    cmd_block  = blk;
    cmd_header = hdr;
    if (skip_running) begin
        // Command arrives while a frame is already on the bus
        fork
            drive_frame(6, 10, 0, 1'b0);
            begin
                idle_cycles(2);
                cmd_req = 1'b1;
            end
        join
    end else begin
        cmd_req = 1'b1;
    end
    idle_cycles(10);
    drive_frame(rows, cols, mode, 1'b1);
    build_expected(hdr);
    wait_ack(1'b1, "capture");
    if (cmd_ack === 1'b1) begin
        check_value("status.word_count", status.word_count, exp_words.size());
        check_value("status.highlight_count", status.highlight_count, exp_high);
        check_value("status.shadow_count", status.shadow_count, exp_shadow);
    end
    if (blk) begin
        blk1_words = exp_words;
    end else begin
        blk0_words = exp_words;
    end
    release_command();
endtask

task automatic read_block(input logic blk, input bit gaps);
    int   n;
    logic trig;
    got_words.delete();
    @(negedge clk);
    cmd_op    = CMD_READOUT;
    cmd_block = blk;
    cmd_req   = 1'b1;
    n = 0;
    do begin
        @(negedge clk);
        n++;
        if (!cmd_ack) begin
            trig = gaps ? (($random(seed) & 3) != 0) : 1'b1;
            readout_trigger = trig;
            // Transfer happens on the next rising edge
            if (readout_ready && trig) begin
                got_words.push_back(readout_data);
            end
        end
    end while (!cmd_ack && (n < ACK_LIMIT));
    readout_trigger = 1'b0;
    if (!cmd_ack) begin
        $display("Timeout: readout of block %0d was never acknowledged", blk);
        timeouts++;
    end
    release_command();
endtask

// ================================================
// Readout checks
// ================================================
task automatic compare_readout(input logic blk);
    logic [15:0] exp_q [$];
    if (blk) begin
        exp_q = blk1_words;
    end else begin
        exp_q = blk0_words;
    end
    if (got_words.size() != exp_q.size()) begin
        $display("[ERROR] readout word count of block %0d: got %h expected %h",
                 blk, got_words.size(), exp_q.size());
        errors++;
    end
    for (int i = 0; (i < got_words.size()) && (i < exp_q.size()); i++) begin
        if (got_words[i] !== exp_q[i]) begin
            $display("[ERROR] readout_data word %0d: got %h expected %h",
                     i, got_words[i], exp_q[i]);
            errors++;
        end
    end
endtask

// Last two readout words against the Fletcher rule over the model's stored words
task automatic verify_checksum(input logic blk);
    logic [15:0] exp_q [$];
    int          a;
    int          b;
    int          n;
    if (blk) begin
        exp_q = blk1_words;
    end else begin
        exp_q = blk0_words;
    end
    n = got_words.size();
    if (n < 2) begin
        $display("Checksum check found fewer than two readout words");
        errors++;
    end else begin
        a = 0;
        b = 0;
        // Header and pixel words only
        for (int i = 0; i < exp_q.size() - 2; i++) begin
            a = (a + exp_q[i]) % 65535;
            b = (b + a) % 65535;
        end
        check_value("readout_data checksum a", got_words[n-2], a);
        check_value("readout_data checksum b", got_words[n-1], b);
    end
endtask

`endif

// File: test/img_tb.sv
`timescale 1ns/1ps
`default_nettype none

module img_tb;
    import img_pkg::*;

    localparam int HEADER_WORDS = 4;
    localparam int MAX_WORDS    = 128;
    localparam int HDR_W        = HEADER_WORDS * 16;
    localparam int ACK_LIMIT    = 4000;

    logic               clk;
    logic               readout_rst;
    logic               cmd_req;
    logic               cmd_ack;
    cmd_op_e            cmd_op;
    logic               cmd_block;
    logic [HDR_W-1:0]   cmd_header;
    pixel_bus_t         pix;
    logic               readout_ready;
    logic               readout_trigger;
    logic [15:0]        readout_data;
    capture_status_t    status;

    integer seed;
    int     errors;
    int     timeouts;

    // Reference model
    logic [15:0] pix_words [$];
    logic [15:0] exp_words [$];
    logic [15:0] blk0_words [$];
    logic [15:0] blk1_words [$];
    logic [15:0] got_words [$];
    int          exp_high;
    int          exp_shadow;

    img_top #(
        .HEADER_WORDS  (HEADER_WORDS),
        .MAX_IMG_WORDS (MAX_WORDS)
    ) dut (
        .clk             (clk),
        .readout_rst     (readout_rst),
        .cmd_req         (cmd_req),
        .cmd_ack         (cmd_ack),
        .cmd_op          (cmd_op),
        .cmd_block       (cmd_block),
        .cmd_header      (cmd_header),
        .pix             (pix),
        .readout_ready   (readout_ready),
        .readout_trigger (readout_trigger),
        .readout_data    (readout_data),
        .status          (status)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    `include "img_tb_tasks.svh"

    // ================================================
    // Directed tests
    // ================================================
    task automatic reset_and_empty_readout();
        @(negedge clk);
        check_value("cmd_ack", cmd_ack, 0);
        check_value("readout_ready", readout_ready, 0);
        // Neither block captured yet
        read_block(1'b0, 1'b0);
        compare_readout(1'b0);
        read_block(1'b1, 1'b1);
        compare_readout(1'b1);
    endtask

    task automatic capture_skips_running_frame();
        capture_frame(1'b0, random_header(), 4, 6, 0, 1'b1);
        read_block(1'b0, 1'b0);
        compare_readout(1'b0);
    endtask

    task automatic checksum_random_frame();
        capture_frame(1'b1, random_header(), 5, 8, 0, 1'b0);
        read_block(1'b1, 1'b0);
        compare_readout(1'b1);
        verify_checksum(1'b1);
    endtask

    task automatic statistics_pattern();
        // Rows and columns 0, 4 and 8 fall on the sampling grid
        capture_frame(1'b0, random_header(), 9, 9, 1, 1'b0);
    endtask

    task automatic readout_with_gaps();
        read_block(1'b0, 1'b1);
        compare_readout(1'b0);
    endtask

    task automatic two_blocks_and_truncation();
        capture_frame(1'b1, random_header(), 3, 7, 0, 1'b0);
        read_block(1'b0, 1'b1);
        compare_readout(1'b0);
        read_block(1'b1, 1'b1);
        compare_readout(1'b1);
        // 144 pixels do not fit into one block
        capture_frame(1'b1, random_header(), 12, 12, 0, 1'b0);
        read_block(1'b1, 1'b1);
        compare_readout(1'b1);
        verify_checksum(1'b1);
    endtask

    initial begin
        seed            = 32'he3c3;
        errors          = 0;
        timeouts        = 0;
        exp_high        = 0;
        exp_shadow      = 0;
        readout_rst     = 1'b0;
        cmd_req         = 1'b0;
        cmd_op          = CMD_CAPTURE;
        cmd_block       = 1'b0;
        cmd_header      = '0;
        pix             = '0;
        readout_trigger = 1'b0;
        repeat (2) @(negedge clk);
        readout_rst = 1'b1;

        reset_and_empty_readout();
        capture_skips_running_frame();
        checksum_random_frame();
        statistics_pattern();
        readout_with_gaps();
        two_blocks_and_truncation();

        $display("Errors: %0d mismatches, %0d timeouts", errors, timeouts);
        if ((errors == 0) && (timeouts == 0)) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: sim.f
+incdir+test
hdl/img_pkg.sv
hdl/fletcher_checksum.sv
hdl/pixel_stats.sv
hdl/capture_writer.sv
hdl/frame_store.sv
hdl/img_controller.sv
hdl/img_top.sv
test/img_tb.sv

// File: run_sim.sh
#!/bin/bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal --top-module img_tb -f sim.f -o img_sim
sim_out=$(./obj_dir/img_sim)
echo "$sim_out"

if grep -q "STATUS: PASS" <<< "$sim_out"; then
    exit 0
fi
exit 1
